// File: verilog/dot_matrix_pkg.sv
package dot_matrix_pkg;

    // panel geometry
    localparam int NUM_ROWS = 8;
    localparam int NUM_COLS = 8;   // also bits per colour plane

    // glyph table
    localparam int NUM_GLYPHS = 12;
    localparam int GLYPH_W    = 4;
    localparam int ROW_W      = 3;

    // rom word is {red, green}, address is {glyph, row}
    localparam int ROM_ADDR_W = GLYPH_W + ROW_W;
    localparam int ROM_DATA_W = 2 * NUM_COLS;

endpackage

// File: verilog/glyph_bus_if.sv
`timescale 1ns/100ps

interface glyph_bus_if
    import dot_matrix_pkg::*;
();
    logic                  req;
    logic [GLYPH_W-1:0]    rd_glyph;
    logic [ROW_W-1:0]      rd_row;
    logic                  gnt;       // one-cycle pulse
    logic [ROM_DATA_W-1:0] rd_data;
    logic                  rd_valid;  // one cycle after gnt

    modport scanner (
        output req,
        output rd_glyph,
        output rd_row,
        input  gnt,
        input  rd_data,
        input  rd_valid
    );

    modport arbiter (
        input  req,
        input  rd_glyph,
        input  rd_row,
        output gnt,
        output rd_data,
        output rd_valid
    );

endinterface

// File: verilog/glyph_rom.sv
`timescale 1ns/100ps

module glyph_rom
    import dot_matrix_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [ROM_ADDR_W-1:0] rom_addr,
    output logic [ROM_DATA_W-1:0] rom_data
);

    logic [GLYPH_W-1:0]  glyph;
    logic [ROW_W-1:0]    row;
    logic [NUM_COLS-1:0] green;
    logic [NUM_COLS-1:0] red;

    assign glyph = rom_addr[ROM_ADDR_W-1 -: GLYPH_W];
    assign row   = rom_addr[ROW_W-1:0];

    always_comb
    begin
        green = '0;
        case (glyph)
            4'd0:
                case (row)
                    3'd2, 3'd5: green = 8'b0001_1000;
                    3'd3, 3'd4: green = 8'b0011_1100;
                    default:    green = '0;
                endcase
            4'd1:
                case (row)
                    3'd2, 3'd5: green = 8'b0011_1000;
                    3'd3, 3'd4: green = 8'b0111_1100;
                    default:    green = '0;
                endcase
            4'd2:
                case (row)
                    3'd2, 3'd5: green = 8'b0011_1100;
                    3'd3, 3'd4: green = 8'b0111_1110;
                    default:    green = '0;
                endcase
            4'd3:
                case (row)
                    3'd1, 3'd6:             green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: green = 8'b0111_1110;
                    default:                green = '0;
                endcase
            4'd4:
                case (row)
                    3'd0, 3'd7: green = 8'b0011_1100;
                    3'd1, 3'd6: green = 8'b0111_1110;
                    default:    green = 8'b1111_1111;
                endcase
            4'd5: green = 8'b1111_1111;  // full panel
            4'd6:
                case (row)
                    3'd0: green = 8'b1100_0011;
                    3'd1: green = 8'b1110_0011;
                    3'd2: green = 8'b1111_0001;
                    3'd3: green = 8'b1110_0011;
                    3'd4: green = 8'b1100_0111;
                    3'd5: green = 8'b1110_0111;
                    3'd6: green = 8'b1111_0111;
                    default: green = 8'b1111_1011;
                endcase
            4'd7:
                case (row)
                    3'd1: green = 8'b0000_0001;
                    3'd2: green = 8'b1000_0001;
                    3'd3: green = 8'b1100_0011;
                    3'd4: green = 8'b1000_0011;
                    3'd5: green = 8'b1100_0111;
                    3'd6: green = 8'b1110_0111;
                    3'd7: green = 8'b1111_0011;
                    default: green = '0;
                endcase
            4'd8:
                case (row)
                    3'd1: green = 8'b0011_1000;
                    3'd2: green = 8'b0100_0100;
                    3'd3: green = 8'b0101_1010;
                    3'd4: green = 8'b0100_1010;
                    3'd5: green = 8'b0011_0010;
                    3'd6: green = 8'b1100_0100;
                    3'd7: green = 8'b0011_1000;
                    default: green = '0;
                endcase
            4'd9:
                case (row)
                    3'd2: green = 8'b0110_0000;
                    3'd3: green = 8'b1111_1100;
                    3'd4: green = 8'b0011_1111;
                    3'd5: green = 8'b0011_1110;
                    3'd6: green = 8'b0001_1100;
                    default: green = '0;
                endcase
            4'd10:
                case (row)
                    3'd2:       green = 8'b0001_1000;
                    3'd3:       green = 8'b0011_1100;
                    3'd4, 3'd5: green = 8'b0111_1110;
                    3'd6:       green = 8'b0010_0100;
                    default:    green = '0;
                endcase
            4'd11:
                case (row)
                    3'd0: green = 8'b1110_0000;
                    3'd1: green = 8'b0110_0000;
                    3'd2: green = 8'b1110_0000;
                    3'd3: green = 8'b0011_0000;
                    3'd4: green = 8'b0011_0001;
                    3'd5: green = 8'b0011_0011;
                    3'd6: green = 8'b0011_1110;
                    default: green = 8'b0001_1100;
                endcase
            default: green = '0;  // unused glyph numbers show blank
        endcase
    end

    // most glyphs light red on the same dots as green
    always_comb
    begin
        red = green;
        case (glyph)
            4'd8:
                case (row)
                    3'd2:       red = 8'b0011_1000;
                    3'd3, 3'd4: red = 8'b0010_0100;
                    3'd5:       red = 8'b0001_1000;
                    default:    red = '0;
                endcase
            4'd10: red = '0;
            4'd11:
                case (row)
                    3'd0, 3'd2: red = 8'b0000_0111;
                    3'd1:       red = 8'b0000_0110;
                    3'd3:       red = 8'b0000_1100;
                    3'd4:       red = 8'b1000_1100;
                    3'd5:       red = 8'b1100_1100;
                    3'd6:       red = 8'b0111_1100;
                    default:    red = 8'b0011_1000;
                endcase
            default: red = green;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rom_data <= '0;
        else
            rom_data <= {red, green};
    end

endmodule

// File: verilog/glyph_arbiter.sv
`timescale 1ns/100ps

module glyph_arbiter
    import dot_matrix_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [ROM_DATA_W-1:0] rom_data,
    glyph_bus_if.arbiter          client_a,
    glyph_bus_if.arbiter          client_b,
    output logic [ROM_ADDR_W-1:0] rom_addr
);

    logic last_b;   // b got the previous grant
    logic gnt_a;
    logic gnt_b;
    logic vld_a;
    logic vld_b;

    // a single requester wins at once, a tie goes to whoever waited
    assign gnt_a = client_a.req && (!client_b.req || last_b);
    assign gnt_b = client_b.req && (!client_a.req || !last_b);

    assign rom_addr = gnt_b ? {client_b.rd_glyph, client_b.rd_row}
                            : {client_a.rd_glyph, client_a.rd_row};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_b <= 1'b0;
            vld_a  <= 1'b0;
            vld_b  <= 1'b0;
        end
        else
        begin
            if (gnt_a)
                last_b <= 1'b0;
            else if (gnt_b)
                last_b <= 1'b1;
            vld_a <= gnt_a;   // rom answers next cycle
            vld_b <= gnt_b;
        end
    end

    assign client_a.gnt      = gnt_a;
    assign client_b.gnt      = gnt_b;
    assign client_a.rd_data  = rom_data;
    assign client_b.rd_data  = rom_data;
    assign client_a.rd_valid = vld_a;
    assign client_b.rd_valid = vld_b;

    // loser of a tie is served on the next cycle
    a_tie_served: assert property (@(posedge clk) disable iff (rst)
        client_a.req && client_b.req
        |=> (client_a.gnt || !client_a.req) && (client_b.gnt || !client_b.req));

    // data only comes back once the client has dropped its request
    a_valid_idle: assert property (@(posedge clk) disable iff (rst)
        !(client_a.rd_valid && client_a.req) && !(client_b.rd_valid && client_b.req));

endmodule

// File: verilog/panel_scan.sv
`timescale 1ns/100ps

module panel_scan
    import dot_matrix_pkg::*;
#(
    parameter int ROW_HOLD = 4
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic               st,
    input  logic               temp,
    input  logic [GLYPH_W-1:0] glyph,
    glyph_bus_if.scanner       bus,
    output logic [NUM_ROWS-1:0] row,
    output logic [NUM_COLS-1:0] colg,
    output logic [NUM_COLS-1:0] colr
);

    localparam int HOLD_W = (ROW_HOLD > 1) ? $clog2(ROW_HOLD) : 1;

    localparam logic [1:0] REQUEST = 2'd0;
    localparam logic [1:0] WAIT    = 2'd1;
    localparam logic [1:0] HOLD    = 2'd2;

    logic             blank;
    logic [1:0]       state;
    logic [HOLD_W-1:0] hold_cnt;
    logic             temp_q;
    logic [ROW_W-1:0] next_row;

    assign blank = rst || !st;   // st low blanks the panel at once

    assign next_row = (bus.rd_row == ROW_W'(NUM_ROWS - 1)) ? '0 : bus.rd_row + 1'b1;

    // rd_glyph doubles as the per-frame glyph latch
    always_ff @(posedge clk or posedge blank)
    begin
        if (blank)
        begin
            state        <= REQUEST;
            bus.req      <= 1'b0;
            bus.rd_glyph <= '0;
            bus.rd_row   <= '0;
            temp_q       <= 1'b0;
            hold_cnt     <= '0;
            row          <= '1;
            colg         <= '0;
            colr         <= '0;
        end
        else
        begin
            case (state)
                REQUEST:
                begin
                    if (!bus.req)
                    begin
                        bus.req      <= 1'b1;   // first row 0 after blanking
                        bus.rd_glyph <= glyph;
                        temp_q       <= temp;
                    end
                    else if (bus.gnt)
                    begin
                        bus.req <= 1'b0;
                        state   <= WAIT;
                    end
                end
                WAIT:
                begin
                    if (bus.rd_valid)
                    begin
                        row      <= ~(NUM_ROWS'(1) << bus.rd_row);
                        colg     <= bus.rd_data[NUM_COLS-1:0];
                        colr     <= temp_q ? bus.rd_data[ROM_DATA_W-1 -: NUM_COLS] : '0;
                        hold_cnt <= '0;
                        state    <= HOLD;
                    end
                end
                HOLD:
                begin
                    if (hold_cnt == HOLD_W'(ROW_HOLD - 1))
                    begin
                        bus.req    <= 1'b1;
                        bus.rd_row <= next_row;
                        if (next_row == '0)
                        begin
                            bus.rd_glyph <= glyph;   // new frame
                            temp_q       <= temp;
                        end
                        state <= REQUEST;
                    end
                    else
                        hold_cnt <= hold_cnt + 1'b1;
                end
                default: state <= REQUEST;
            endcase
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (blank)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.rd_glyph) && $stable(bus.rd_row));

    a_row_one_cold: assert property (@(posedge clk) $onehot0(~row));

endmodule

// File: verilog/dot_matrix_top.sv
`timescale 1ns/100ps

module dot_matrix_top
    import dot_matrix_pkg::*;
#(
    parameter int ROW_HOLD = 4
)
(
    input  logic                clk,
    input  logic                rst,
    input  logic                st,
    input  logic                temp,
    input  logic [GLYPH_W-1:0]  glyph_a,
    input  logic [GLYPH_W-1:0]  glyph_b,
    output logic [NUM_ROWS-1:0] row_a,
    output logic [NUM_COLS-1:0] colg_a,
    output logic [NUM_COLS-1:0] colr_a,
    output logic [NUM_ROWS-1:0] row_b,
    output logic [NUM_COLS-1:0] colg_b,
    output logic [NUM_COLS-1:0] colr_b
);

    logic [ROM_ADDR_W-1:0] rom_addr;
    logic [ROM_DATA_W-1:0] rom_data;

    glyph_bus_if bus_a ();
    glyph_bus_if bus_b ();

    panel_scan #(.ROW_HOLD(ROW_HOLD)) u_scan_a (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .temp  (temp),
        .glyph (glyph_a),
        .bus   (bus_a),
        .row   (row_a),
        .colg  (colg_a),
        .colr  (colr_a)
    );

    panel_scan #(.ROW_HOLD(ROW_HOLD)) u_scan_b (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .temp  (temp),
        .glyph (glyph_b),
        .bus   (bus_b),
        .row   (row_b),
        .colg  (colg_b),
        .colr  (colr_b)
    );

    glyph_arbiter u_arb (
        .clk      (clk),
        .rst      (rst),
        .rom_data (rom_data),
        .client_a (bus_a),
        .client_b (bus_b),
        .rom_addr (rom_addr)
    );

    glyph_rom u_rom (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

endmodule

// File: tb/tb_dot_matrix.sv
`timescale 1ns/100ps

module tb_dot_matrix
    import dot_matrix_pkg::*;
();

    localparam int ROW_HOLD   = 4;
    localparam int CLK_PERIOD = 40;
    localparam int ROW_CYCLES = ROW_HOLD + 3;   // worst-case row period
    localparam int TABLE_LEN  = NUM_GLYPHS * NUM_ROWS;

    logic                clk;
    logic                rst;
    logic                st;
    logic                temp;
    logic [GLYPH_W-1:0]  glyph_a;
    logic [GLYPH_W-1:0]  glyph_b;
    logic [NUM_ROWS-1:0] row_a;
    logic [NUM_COLS-1:0] colg_a;
    logic [NUM_COLS-1:0] colr_a;
    logic [NUM_ROWS-1:0] row_b;
    logic [NUM_COLS-1:0] colg_b;
    logic [NUM_COLS-1:0] colr_b;

    logic [NUM_COLS-1:0] tbl_green [TABLE_LEN];
    logic [NUM_COLS-1:0] tbl_red [TABLE_LEN];
    int                  step_ga [$];
    int                  step_gb [$];
    int                  step_temp [$];
    int                  step_st [$];
    int                  step_frames [$];

    // monitor state, index 0 is panel a
    logic [NUM_ROWS-1:0] prev_row [2];
    int                  last_idx [2];
    bit                  fresh [2];
    logic [GLYPH_W-1:0]  frame_glyph [2];
    logic                frame_temp [2];
    int                  frames [2];
    int                  frames_a;
    int                  idx_a;
    bit                  limit_ready;
    time                 limit_ns;

    dot_matrix_top #(.ROW_HOLD(ROW_HOLD)) u_dut (
        .clk     (clk),
        .rst     (rst),
        .st      (st),
        .temp    (temp),
        .glyph_a (glyph_a),
        .glyph_b (glyph_b),
        .row_a   (row_a),
        .colg_a  (colg_a),
        .colr_a  (colr_a),
        .row_b   (row_b),
        .colg_b  (colg_b),
        .colr_b  (colr_b)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_plane(input string what, input logic [NUM_COLS-1:0] got,
                               input logic [NUM_COLS-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "column check failed");
        end
    endtask

    task automatic check_row_line(input string what, input logic [NUM_ROWS-1:0] got,
                                  input logic [NUM_ROWS-1:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "row check failed");
        end
    endtask

    // all rows dark except the lit one, active low
    function automatic logic [NUM_ROWS-1:0] lit_row(input int idx);
        logic [NUM_ROWS-1:0] pattern;
        pattern      = '1;
        pattern[idx] = 1'b0;
        return pattern;
    endfunction

    function automatic logic [NUM_COLS-1:0] expected_green(input logic [GLYPH_W-1:0] g,
                                                           input int r);
        int gi;
        gi = int'(g);
        if (gi >= NUM_GLYPHS)
            return '0;   // glyphs 12..15 blank
        return tbl_green[gi * NUM_ROWS + r];
    endfunction

    function automatic logic [NUM_COLS-1:0] expected_red(input logic [GLYPH_W-1:0] g,
                                                         input int r, input logic t);
        int gi;
        gi = int'(g);
        if (!t || gi >= NUM_GLYPHS)
            return '0;
        return tbl_red[gi * NUM_ROWS + r];
    endfunction

    task automatic observe_panel(input int p, input string name, input logic [NUM_ROWS-1:0] r,
                                 input logic [NUM_COLS-1:0] g, input logic [NUM_COLS-1:0] rd,
                                 input logic [GLYPH_W-1:0] glyph_in);
        int exp_idx;
        if (r == '1)
            fresh[p] = 1'b1;   // blanked, next lit row is row 0
        else if (r != prev_row[p])
        begin
            exp_idx = fresh[p] ? 0 : (last_idx[p] + 1) % NUM_ROWS;
            check_row_line({name, " row"}, r, lit_row(exp_idx));
            if (exp_idx == 0)
            begin
                frame_glyph[p] = glyph_in;   // inputs only change mid-frame
                frame_temp[p]  = temp;
                frames[p]++;
            end
            check_plane({name, " colg"}, g, expected_green(frame_glyph[p], exp_idx));
            check_plane({name, " colr"}, rd,
                        expected_red(frame_glyph[p], exp_idx, frame_temp[p]));
            last_idx[p] = exp_idx;
            fresh[p]    = 1'b0;
        end
        prev_row[p] = r;
    endtask

    always @(negedge clk)
    begin
        if (rst || !st)
        begin
            check_row_line("panel a blank row", row_a, '1);
            check_row_line("panel b blank row", row_b, '1);
            check_plane("panel a blank colg", colg_a, '0);
            check_plane("panel a blank colr", colr_a, '0);
            check_plane("panel b blank colg", colg_b, '0);
            check_plane("panel b blank colr", colr_b, '0);
        end
        observe_panel(0, "panel a", row_a, colg_a, colr_a, glyph_a);
        observe_panel(1, "panel b", row_b, colg_b, colr_b, glyph_b);
        frames_a = frames[0];
        idx_a    = last_idx[0];
    end

    initial
    begin
        wait (limit_ready);
        #(limit_ns);
        $display("timeout: the run did not finish within %0t ns", limit_ns);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        int    fd;
        int    n;
        int    loaded;
        int    live_frames;
        int    total_frames;
        int    target;
        int    g;
        int    r;
        int    a;
        int    b;
        int    c;
        int    d;
        int    e;
        bit    blanked;
        string line;

        clk = 1'b0;
        rst = 1'b1;
        st = 1'b0;
        temp = 1'b0;
        glyph_a = '0;
        glyph_b = '0;
        limit_ready = 1'b0;
        frames_a = 0;
        idx_a = 0;
        for (int p = 0; p < 2; p++)
        begin
            prev_row[p] = '1;
            last_idx[p] = 0;
            fresh[p] = 1'b1;
            frame_glyph[p] = '0;
            frame_temp[p] = 1'b0;
            frames[p] = 0;
        end

        fd = $fopen("tb/dot_matrix_stim.txt", "r");
        if (fd == 0)
            abort_run("cannot open tb/dot_matrix_stim.txt");
        loaded = 0;
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            if (loaded < TABLE_LEN)
            begin
                n = $sscanf(line, "%d %d %h %h", g, r, a, b);
                if (n != 4 || g < 0 || g >= NUM_GLYPHS || r < 0 || r >= NUM_ROWS)
                    abort_run({"bad glyph table line: ", line});
                tbl_green[g * NUM_ROWS + r] = NUM_COLS'(a);
                tbl_red[g * NUM_ROWS + r]   = NUM_COLS'(b);
                loaded++;
            end
            else
            begin
                n = $sscanf(line, "%d %d %d %d %d", a, b, c, d, e);
                if (n != 5)
                    abort_run({"bad step line: ", line});
                step_ga.push_back(a);
                step_gb.push_back(b);
                step_temp.push_back(c);
                step_st.push_back(d);
                step_frames.push_back(e);
            end
        end
        $fclose(fd);
        if (loaded != TABLE_LEN || step_ga.size() == 0)
            abort_run("stim file holds an incomplete glyph table or no steps");

        total_frames = 0;
        live_frames = 0;
        foreach (step_frames[i])
        begin
            total_frames += step_frames[i];
            if (step_st[i] != 0)
                live_frames += step_frames[i];
        end
        // margin of one frame per step for the mid-frame input changes
        limit_ns = (total_frames + step_frames.size() + 4) * NUM_ROWS * ROW_CYCLES * CLK_PERIOD;
        limit_ready = 1'b1;

        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        blanked = 1'b1;

        foreach (step_ga[i])
        begin
            if (!blanked)
            begin
                wait (idx_a == 3);
                @(posedge clk);
                #2;
            end
            glyph_a = GLYPH_W'(step_ga[i]);
            glyph_b = GLYPH_W'(step_gb[i]);
            temp    = step_temp[i] != 0;
            st      = step_st[i] != 0;
            if (st)
            begin
                target = frames_a + step_frames[i];
                wait (frames_a >= target);
                blanked = 1'b0;
            end
            else
            begin
                repeat (step_frames[i] * NUM_ROWS * ROW_CYCLES) @(posedge clk);
                #2;
                blanked = 1'b1;
            end
        end

        repeat (2) @(posedge clk);
        if (frames[1] + 1 >= live_frames)
        begin
            $display("Simulation PASSED");
            $finish;
        end
        else
        begin
            $display("panel b completed only %0d of %0d frames", frames[1], live_frames);
            $display("Simulation FAILED");
            $fatal(1, "panel b starved");
        end
    end

endmodule

// File: tb/dot_matrix_stim.txt
# glyph table, 96 lines: glyph row green red (glyph and row decimal, planes hex)
# then steps: glyph_a glyph_b temp st frames (decimal)
0 0 00 00
0 1 00 00
0 2 18 18
0 3 3c 3c
0 4 3c 3c
0 5 18 18
0 6 00 00
0 7 00 00
1 0 00 00
1 1 00 00
1 2 38 38
1 3 7c 7c
1 4 7c 7c
1 5 38 38
1 6 00 00
1 7 00 00
2 0 00 00
2 1 00 00
2 2 3c 3c
2 3 7e 7e
2 4 7e 7e
2 5 3c 3c
2 6 00 00
2 7 00 00
3 0 00 00
3 1 3c 3c
3 2 7e 7e
3 3 7e 7e
3 4 7e 7e
3 5 7e 7e
3 6 3c 3c
3 7 00 00
4 0 3c 3c
4 1 7e 7e
4 2 ff ff
4 3 ff ff
4 4 ff ff
4 5 ff ff
4 6 7e 7e
4 7 3c 3c
5 0 ff ff
5 1 ff ff
5 2 ff ff
5 3 ff ff
5 4 ff ff
5 5 ff ff
5 6 ff ff
5 7 ff ff
6 0 c3 c3
6 1 e3 e3
6 2 f1 f1
6 3 e3 e3
6 4 c7 c7
6 5 e7 e7
6 6 f7 f7
6 7 fb fb
7 0 00 00
7 1 01 01
7 2 81 81
7 3 c3 c3
7 4 83 83
7 5 c7 c7
7 6 e7 e7
7 7 f3 f3
8 0 00 00
8 1 38 00
8 2 44 38
8 3 5a 24
8 4 4a 24
8 5 32 18
8 6 c4 00
8 7 38 00
9 0 00 00
9 1 00 00
9 2 60 60
9 3 fc fc
9 4 3f 3f
9 5 3e 3e
9 6 1c 1c
9 7 00 00
10 0 00 00
10 1 00 00
10 2 18 00
10 3 3c 00
10 4 7e 00
10 5 7e 00
10 6 24 00
10 7 00 00
11 0 e0 07
11 1 60 06
11 2 e0 07
11 3 30 0c
11 4 31 8c
11 5 33 cc
11 6 3e 7c
11 7 1c 38
0 11 1 1 1
1 10 1 1 1
2 9 1 1 1
3 8 1 1 1
4 7 1 1 1
5 6 1 1 1
6 5 1 1 1
7 4 1 1 1
8 3 1 1 1
9 2 1 1 1
10 1 1 1 1
11 0 1 1 2
8 11 0 1 1
0 0 1 0 1
6 12 0 1 2
10 14 1 1 1
15 13 1 1 1
11 8 1 0 1
4 8 1 1 2

// File: flist.f
verilog/dot_matrix_pkg.sv
verilog/glyph_bus_if.sv
verilog/glyph_rom.sv
verilog/glyph_arbiter.sv
verilog/panel_scan.sv
verilog/dot_matrix_top.sv
tb/tb_dot_matrix.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_dot_matrix \
    -f flist.f -o tb_dot_matrix > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_dot_matrix > sim.log 2>&1 || true
cat sim.log
grep -q "^Simulation PASSED$" sim.log && echo "run ok" || { echo "run failed"; exit 1; }
